//--- project.f
verilog/video_pkg.sv
verilog/bus_pkg.sv
verilog/raster_timer.sv
verilog/star_regs.sv
verilog/star_layer.sv
verilog/star_mixer.sv
verilog/starfield_top.sv
dv/star_model.sv
dv/tb_starfield.sv

//--- run.sh
#!/bin/sh
# Build and run the starfield testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_starfield -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_starfield)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- dv/tb_starfield.sv
module tb_starfield;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_CYCLES = 4 * int'(video_pkg::H_TOTAL) * int'(video_pkg::V_TOTAL);

	logic clk_24 = 1'b0;
	logic rst_n = 1'b0;
	logic ce_6 = 1'b0;
	logic pause = 1'b0;
	bus_pkg::bus_wr_t bus = '0;

	video_pkg::colour_t r;
	video_pkg::colour_t g;
	video_pkg::colour_t b;
	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;
	video_pkg::colour_t exp_r;
	video_pkg::colour_t exp_g;
	video_pkg::colour_t exp_b;
	logic exp_hsync;
	logic exp_vsync;
	logic exp_hblank;
	logic exp_vblank;

	logic [1:0] ce_div = 2'd0;
	int pause_left = 0;
	int cycles = 0;
	int ce_count = 0;
	int line_count = 0;
	int hs_rises = 0;
	int vs_count = 0;
	int lit_pixels = 0;
	logic hs_prev = 1'b0;
	logic vs_prev = 1'b0;

	starfield_top i_dut (
		.clk_24 (clk_24),
		.rst_n  (rst_n),
		.ce_6   (ce_6),
		.pause  (pause),
		.bus    (bus),
		.r      (r),
		.g      (g),
		.b      (b),
		.hsync  (hsync),
		.vsync  (vsync),
		.hblank (hblank),
		.vblank (vblank)
	);

	star_model i_model (
		.clk_24 (clk_24),
		.rst_n  (rst_n),
		.ce_6   (ce_6),
		.pause  (pause),
		.bus    (bus),
		.r      (exp_r),
		.g      (exp_g),
		.b      (exp_b),
		.hsync  (exp_hsync),
		.vsync  (exp_vsync),
		.hblank (exp_hblank),
		.vblank (exp_vblank)
	);

	initial
	begin
		forever #4 clk_24 = ~clk_24;
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	// Mostly layer registers, some pause triggers and some unmapped addresses
	function automatic bus_pkg::bus_wr_t random_write();
		bus_pkg::bus_wr_t w;
		int kind;
		kind = int'($urandom % 16);
		w.wr = 1'b1;
		w.data = 8'($urandom);
		if (kind == 0)
		begin
			w.addr = bus_pkg::REG_PAUSE;
		end
		else if (kind < 3)
		begin
			w.addr = 8'($urandom);
			if ((w.addr < 8'h06) || (w.addr == bus_pkg::REG_PAUSE))
				w.addr = 8'h07;
		end
		else
		begin
			w.addr = 8'(2 * ($urandom % 3) + ($urandom % 2));
		end
		return w;
	endfunction

	task automatic wait_vsync_rise(input int limit);
		int n;
		int start;
		start = vs_count;
		n = 0;
		while (vs_count == start)
		begin
			@(posedge clk_24);
			n++;
			if (n > limit)
			begin
				$display("Timed out after %0d cycles waiting for a vertical sync pulse", limit);
				$display("SIMULATION FAILED");
				$fatal(1, "timeout");
			end
		end
	endtask

	// Drives ce_6 every fourth cycle plus rare writes and pause bursts
	initial
	begin : drive
		void'($urandom(32'hd2e8));
		forever
		begin
			@(posedge clk_24);
			cycles <= cycles + 1;
			ce_div <= ce_div + 2'd1;
			ce_6 <= (ce_div == 2'd3);
			if (rst_n && ($urandom % 2048 == 0))
				bus <= random_write();
			else
				bus <= '0;
			pause <= (pause_left != 0);
			if (pause_left != 0)
				pause_left <= pause_left - 1;
			else if (rst_n && ($urandom % 40000 == 0))
				pause_left <= 1 + int'($urandom % 3000);
		end
	end

	always @(negedge clk_24)
	begin
		if (cycles > 0)
		begin
			compare("r", 32'(r), 32'(exp_r));
			compare("g", 32'(g), 32'(exp_g));
			compare("b", 32'(b), 32'(exp_b));
			compare("hsync", 32'(hsync), 32'(exp_hsync));
			compare("vsync", 32'(vsync), 32'(exp_vsync));
			compare("hblank", 32'(hblank), 32'(exp_hblank));
			compare("vblank", 32'(vblank), 32'(exp_vblank));
			if (r != '0)
				lit_pixels++;
			if (ce_6)
				ce_count++;
			// Line length in pixel steps and frame length in lines
			if (hsync && !hs_prev)
			begin
				if (hs_rises > 0)
					compare("hsync period", ce_count, int'(video_pkg::H_TOTAL));
				ce_count = 0;
				hs_rises++;
				line_count++;
			end
			if (vsync && !vs_prev)
			begin
				if (vs_count > 0)
					compare("vsync period", line_count, int'(video_pkg::V_TOTAL));
				line_count = 0;
				vs_count++;
			end
			hs_prev = hsync;
			vs_prev = vsync;
		end
	end

	initial
	begin
		repeat (5) @(posedge clk_24);
		rst_n <= 1'b1;
		wait_vsync_rise(FRAME_CYCLES + 2000);
		repeat (3)
			wait_vsync_rise(FRAME_CYCLES + 2000);
		if (lit_pixels == 0)
		begin
			$display("No lit star pixel appeared during the whole run");
			$display("SIMULATION FAILED");
			$fatal(1, "no stars");
		end
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- dv/star_model.sv
module star_model #(
	parameter int NUM_LAYERS = video_pkg::NUM_LAYERS
) (
	input  logic               clk_24,
	input  logic               rst_n,
	input  logic               ce_6,
	input  logic               pause,
	input  bus_pkg::bus_wr_t   bus,
	output video_pkg::colour_t r,
	output video_pkg::colour_t g,
	output video_pkg::colour_t b,
	output logic               hsync,
	output logic               vsync,
	output logic               hblank,
	output logic               vblank
);
	timeunit 1ns;
	timeprecision 1ps;

	int h;
	int v;
	logic hb;
	logic vb;
	logic hs;
	logic vs;
	logic trig;
	logic vb_last;
	logic en [NUM_LAYERS];
	bus_pkg::data_t spd [NUM_LAYERS];
	bus_pkg::data_t sk [NUM_LAYERS];
	video_pkg::lfsr_t lf [NUM_LAYERS];
	video_pkg::lfsr_t fs [NUM_LAYERS];
	logic on [NUM_LAYERS];
	video_pkg::colour_t col [NUM_LAYERS];
	logic [3:0] d1;
	logic [3:0] d2;
	video_pkg::colour_t grey;

	// Shift up by one with the parity of the tapped bits entering at the bottom
	function automatic video_pkg::lfsr_t advance(input video_pkg::lfsr_t s,
		input video_pkg::lfsr_t taps);
		return (s << 1) | video_pkg::lfsr_t'(^(s & taps));
	endfunction

	always @(posedge clk_24)
	begin : tick
		int hn;
		int vn;
		int sel;
		logic act;
		logic frz;
		logic found;
		video_pkg::colour_t px;
		if (!rst_n)
		begin
			h <= 0;
			v <= 0;
			hb <= 1'b0;
			vb <= 1'b0;
			hs <= 1'b0;
			vs <= 1'b0;
			trig <= 1'b0;
			vb_last <= 1'b0;
			d1 <= '0;
			d2 <= '0;
			grey <= '0;
			for (int i = 0; i < NUM_LAYERS; i++)
			begin
				en[i] <= 1'b0;
				spd[i] <= '0;
				sk[i] <= '0;
				lf[i] <= video_pkg::LAYER_SEED[i];
				fs[i] <= video_pkg::LAYER_SEED[i];
				on[i] <= 1'b0;
				col[i] <= '0;
			end
		end
		else
		begin
			// Raster position and flags
			hn = (h == int'(video_pkg::H_TOTAL) - 1) ? 0 : h + 1;
			vn = v;
			if (hn == 0)
				vn = (v == int'(video_pkg::V_TOTAL) - 1) ? 0 : v + 1;
			if (ce_6)
			begin
				h <= hn;
				v <= vn;
				hb <= hn >= int'(video_pkg::H_ACTIVE);
				vb <= vn >= int'(video_pkg::V_ACTIVE);
				hs <= (hn >= int'(video_pkg::HS_START)) && (hn < int'(video_pkg::HS_END));
				vs <= (vn >= int'(video_pkg::VS_START)) && (vn < int'(video_pkg::VS_END));
			end

			// Register writes
			sel = int'(bus.addr[2:1]);
			if (bus.wr && ((bus.addr & 8'hF8) == bus_pkg::REG_LAYER_BASE) && (sel < NUM_LAYERS))
			begin
				if (bus.addr[0])
					spd[sel] <= bus.data;
				else
					en[sel] <= bus.data[0];
			end
			if (pause)
				trig <= 1'b0;
			else if (bus.wr && (bus.addr == bus_pkg::REG_PAUSE))
				trig <= 1'b1;

			// Layers
			frz = pause || trig;
			act = !hb && !vb;
			vb_last <= vb;
			for (int i = 0; i < NUM_LAYERS; i++)
			begin
				if (vb && !vb_last)
				begin
					sk[i] <= spd[i];
				end
				else if ((sk[i] != '0) && !frz)
				begin
					fs[i] <= advance(fs[i], video_pkg::LAYER_TAPS[i]);
					sk[i] <= sk[i] - 8'd1;
				end
				if (!vb && vb_last)
					lf[i] <= fs[i];
				else if (ce_6 && !frz && act)
					lf[i] <= advance(lf[i], video_pkg::LAYER_TAPS[i]);
				on[i] <= en[i] && act
					&& ((lf[i] & video_pkg::LAYER_MASK[i]) == video_pkg::LAYER_MASK[i]);
				col[i] <= lf[i][7:0];
			end

			// First lit layer wins and keeps only its low 8 minus index bits
			found = 1'b0;
			px = '0;
			for (int i = 0; i < NUM_LAYERS; i++)
			begin
				if (!found && on[i])
				begin
					px = col[i] & video_pkg::colour_t'((1 << (8 - i)) - 1);
					found = 1'b1;
				end
			end
			if (d1[1] || d1[0])
				px = '0;
			d1 <= {hs, vs, hb, vb};
			d2 <= d1;
			grey <= px;
		end
	end

	assign r = grey;
	assign g = grey;
	assign b = grey;
	assign {hsync, vsync, hblank, vblank} = d2;

endmodule

//--- verilog/starfield_top.sv
module starfield_top #(
	parameter int NUM_LAYERS = video_pkg::NUM_LAYERS
) (
	input  logic               clk_24,
	input  logic               rst_n,
	input  logic               ce_6,
	input  logic               pause,
	input  bus_pkg::bus_wr_t   bus,
	output video_pkg::colour_t r,
	output video_pkg::colour_t g,
	output video_pkg::colour_t b,
	output logic               hsync,
	output logic               vsync,
	output logic               hblank,
	output logic               vblank
);

	video_pkg::raster_t raster;
	bus_pkg::layer_cfg_t cfg [NUM_LAYERS];
	video_pkg::star_pix_t stars [NUM_LAYERS];
	logic freeze;

	raster_timer i_timer (
		.clk_24 (clk_24),
		.rst_n  (rst_n),
		.ce_6   (ce_6),
		.raster (raster)
	);

	star_regs #(.NUM_LAYERS(NUM_LAYERS)) i_regs (
		.clk_24 (clk_24),
		.rst_n  (rst_n),
		.bus    (bus),
		.pause  (pause),
		.cfg    (cfg),
		.freeze (freeze)
	);

	for (genvar i = 0; i < NUM_LAYERS; i++)
	begin : g_layer
		star_layer #(.LAYER(i)) i_layer (
			.clk_24 (clk_24),
			.rst_n  (rst_n),
			.ce_6   (ce_6),
			.raster (raster),
			.cfg    (cfg[i]),
			.freeze (freeze),
			.star   (stars[i])
		);
	end

	star_mixer #(.NUM_LAYERS(NUM_LAYERS)) i_mixer (
		.clk_24 (clk_24),
		.rst_n  (rst_n),
		.raster (raster),
		.stars  (stars),
		.r      (r),
		.g      (g),
		.b      (b),
		.hsync  (hsync),
		.vsync  (vsync),
		.hblank (hblank),
		.vblank (vblank)
	);

endmodule

//--- verilog/star_mixer.sv
module star_mixer #(
	parameter int NUM_LAYERS = video_pkg::NUM_LAYERS
) (
	input  logic                 clk_24,
	input  logic                 rst_n,
	input  video_pkg::raster_t   raster,
	input  video_pkg::star_pix_t stars [NUM_LAYERS],
	output video_pkg::colour_t   r,
	output video_pkg::colour_t   g,
	output video_pkg::colour_t   b,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 hblank,
	output logic                 vblank
);

	// Flags as {hsync, vsync, hblank, vblank}
	logic [3:0] flags_q1;
	logic [3:0] flags_q2;
	video_pkg::colour_t grey;
	video_pkg::colour_t grey_q;

	// Walk down so the lowest lit layer is the last to assign
	always_comb
	begin
		grey = '0;
		for (int i = NUM_LAYERS - 1; i >= 0; i--)
		begin
			if (stars[i].on)
				grey = stars[i].colour & (8'hFF >> i);
		end
		if (flags_q1[1] || flags_q1[0])
			grey = '0;
	end

	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			flags_q1 <= '0;
			flags_q2 <= '0;
			grey_q <= '0;
		end
		else
		begin
			flags_q1 <= {raster.hsync, raster.vsync, raster.hblank, raster.vblank};
			flags_q2 <= flags_q1;
			grey_q <= grey;
		end
	end

	assign r = grey_q;
	assign g = grey_q;
	assign b = grey_q;
	assign {hsync, vsync, hblank, vblank} = flags_q2;

endmodule

//--- verilog/star_layer.sv
module star_layer #(
	parameter int LAYER = 0
) (
	input  logic                  clk_24,
	input  logic                  rst_n,
	input  logic                  ce_6,
	input  video_pkg::raster_t    raster,
	input  bus_pkg::layer_cfg_t   cfg,
	input  logic                  freeze,
	output video_pkg::star_pix_t  star
);

	localparam video_pkg::lfsr_t SEED = video_pkg::LAYER_SEED[LAYER];
	localparam video_pkg::lfsr_t MASK = video_pkg::LAYER_MASK[LAYER];
	localparam video_pkg::lfsr_t TAPS = video_pkg::LAYER_TAPS[LAYER];

	video_pkg::lfsr_t lfsr;
	video_pkg::lfsr_t frame_start;
	bus_pkg::data_t skip;
	logic vblank_q;
	logic active;
	logic vb_rise;
	logic vb_fall;

	// Shift left, feedback from the tapped bits into bit 0
	function automatic video_pkg::lfsr_t lfsr_step(input video_pkg::lfsr_t s);
		return {s[video_pkg::LFSR_LEN-2:0], ^(s & TAPS)};
	endfunction

	assign active = !raster.hblank && !raster.vblank;
	assign vb_rise = raster.vblank && !vblank_q;
	assign vb_fall = !raster.vblank && vblank_q;

	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			lfsr <= SEED;
			frame_start <= SEED;
			skip <= '0;
			vblank_q <= 1'b0;
			star <= '0;
		end
		else
		begin
			vblank_q <= raster.vblank;

			// Scroll by advancing the frame start during vertical blank
			if (vb_rise)
			begin
				skip <= cfg.speed;
			end
			else if ((skip != '0) && !freeze)
			begin
				frame_start <= lfsr_step(frame_start);
				skip <= skip - 8'd1;
			end

			// Reseed as the visible frame begins
			if (vb_fall)
				lfsr <= frame_start;
			else if (ce_6 && !freeze && active)
				lfsr <= lfsr_step(lfsr);

			star.on <= cfg.enable && active && ((lfsr & MASK) == MASK);
			star.colour <= lfsr[7:0];
		end
	end

endmodule

//--- verilog/star_regs.sv
module star_regs #(
	parameter int NUM_LAYERS = video_pkg::NUM_LAYERS
) (
	input  logic                clk_24,
	input  logic                rst_n,
	input  bus_pkg::bus_wr_t    bus,
	input  logic                pause,
	output bus_pkg::layer_cfg_t cfg [NUM_LAYERS],
	output logic                freeze
);

	logic [1:0] layer_sel;
	logic layer_hit;
	logic pause_hit;
	logic pause_trig;

	assign layer_sel = bus.addr[2:1];

	// Layers past the configured count fall through as unmapped
	assign layer_hit = bus.wr
		&& (bus.addr[7:3] == bus_pkg::REG_LAYER_BASE[7:3])
		&& (int'(layer_sel) < NUM_LAYERS);
	assign pause_hit = bus.wr && (bus.addr == bus_pkg::REG_PAUSE);

	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_LAYERS; i++)
				cfg[i] <= '0;
		end
		else if (layer_hit)
		begin
			for (int i = 0; i < NUM_LAYERS; i++)
			begin
				if (layer_sel == 2'(i))
				begin
					if (bus.addr[0])
						cfg[i].speed <= bus.data;
					else
						cfg[i].enable <= bus.data[0];
				end
			end
		end
	end

	// Pause input releases the trigger and wins over a new write
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			pause_trig <= 1'b0;
		else if (pause)
			pause_trig <= 1'b0;
		else if (pause_hit)
			pause_trig <= 1'b1;
	end

	assign freeze = pause || pause_trig;

endmodule

//--- verilog/raster_timer.sv
module raster_timer (
	input  logic               clk_24,
	input  logic               rst_n,
	input  logic               ce_6,
	output video_pkg::raster_t raster
);

	video_pkg::count_t h_next;
	video_pkg::count_t v_next;

	// Next pixel and line position
	always_comb
	begin
		h_next = raster.hcnt;
		v_next = raster.vcnt;
		if (raster.hcnt == video_pkg::H_TOTAL - 9'd1)
		begin
			h_next = '0;
			if (raster.vcnt == video_pkg::V_TOTAL - 9'd1)
				v_next = '0;
			else
				v_next = raster.vcnt + 9'd1;
		end
		else
		begin
			h_next = raster.hcnt + 9'd1;
		end
	end

	// Flags follow the new position in the same step
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			raster <= '0;
		end
		else if (ce_6)
		begin
			raster.hcnt <= h_next;
			raster.vcnt <= v_next;
			raster.hblank <= h_next >= video_pkg::H_ACTIVE;
			raster.vblank <= v_next >= video_pkg::V_ACTIVE;
			raster.hsync <= (h_next >= video_pkg::HS_START) && (h_next < video_pkg::HS_END);
			raster.vsync <= (v_next >= video_pkg::VS_START) && (v_next < video_pkg::VS_END);
		end
	end

endmodule

//--- verilog/bus_pkg.sv
package bus_pkg;

	typedef logic [7:0] addr_t;
	typedef logic [7:0] data_t;

	// Single-cycle write strobe from the CPU side
	typedef struct packed {
		logic wr;
		addr_t addr;
		data_t data;
	} bus_wr_t;

	typedef struct packed {
		logic enable;
		data_t speed;
	} layer_cfg_t;

	// Layer block, bits 2:1 pick the layer and bit 0 the register
	localparam addr_t REG_LAYER_BASE = 8'h00;
	localparam addr_t REG_PAUSE = 8'h30;

endpackage

//--- verilog/video_pkg.sv
package video_pkg;

	typedef logic [8:0] count_t;
	typedef logic [7:0] colour_t;
	typedef logic [21:0] lfsr_t;

	// Frame and active area, in pixels and lines
	localparam count_t H_TOTAL = 9'd396;
	localparam count_t V_TOTAL = 9'd256;
	localparam count_t H_ACTIVE = 9'd320;
	localparam count_t V_ACTIVE = 9'd240;
	localparam count_t HS_START = 9'd336;
	localparam count_t HS_END = 9'd368;
	localparam count_t VS_START = 9'd244;
	localparam count_t VS_END = 9'd247;

	localparam int NUM_LAYERS = 3;
	localparam int LFSR_LEN = 22;

	typedef struct packed {
		count_t hcnt;
		count_t vcnt;
		logic hblank;
		logic vblank;
		logic hsync;
		logic vsync;
	} raster_t;

	typedef struct packed {
		logic on;
		colour_t colour;
	} star_pix_t;

	// Per-layer LFSR tables, narrower layers zero-extended to 22 bits
	localparam lfsr_t LAYER_SEED [3] = '{22'h1FFFFF, 22'h1FFFF0, 22'h1FFF00};
	localparam lfsr_t LAYER_MASK [3] = '{
		22'b0000111100001111000011,
		22'b0000011110000111100001,
		22'b0000011110000111100001
	};
	localparam lfsr_t LAYER_TAPS [3] = '{
		22'b1100000000000000000000,
		22'b0101010000000000000000,
		22'b0101000000000000000000
	};

endpackage
